// File: cpu_pkg.sv
//////////////////////////////
// Sizes, opcodes and pipeline words shared by the CPU.
// Modules import it inside their body.
//////////////////////////////
package cpu_pkg;

    //////////////////////////////
    // Sizes.
    //////////////////////////////
    localparam int data_w     = 8;   // Register and data memory width.
    localparam int reg_n      = 4;   // Architectural registers.
    localparam int reg_aw     = 2;   // Register index width.
    localparam int dmem_depth = 16;  // Data memory words.
    localparam int dmem_aw    = 4;   // Data memory address width.
    localparam int imem_depth = 64;  // Instruction ROM words.
    localparam int pc_w       = 6;   // Program counter width.
    localparam int instr_w    = 16;  // Instruction word width.
    localparam int seq_w      = 8;   // Sequence ids and stall counts.
    localparam int cyc_w      = 16;  // Free-running cycle counter.

    // Opcode field, bits 15..12 of the instruction.
    typedef enum logic [3:0] {
        NOP    = 4'h0,
        LDI    = 4'h1,  // rd = imm.
        ADD    = 4'h2,  // rd = rd + rs.
        SUB    = 4'h3,  // rd = rd - rs.
        AND_OP = 4'h4,  // rd = rd & rs.
        XOR_OP = 4'h5,  // rd = rd ^ rs.
        LD     = 4'h6,  // rd = mem[rs + imm].
        ST     = 4'h7,  // mem[rs + imm] = rd.
        HLT    = 4'h8   // Stop fetching.
    } opcode_e;

    // Instruction layout.
    typedef struct packed {
        opcode_e             op;   // 15..12.
        logic [reg_aw-1:0]   rd;   // 11..10.
        logic [reg_aw-1:0]   rs;   // 9..8.
        logic [data_w-1:0]   imm;  // 7..0.
    } instr_t;

    // Destination of an in-flight instruction, for the interlock.
    typedef struct packed {
        logic                wr;
        logic [reg_aw-1:0]   rd;
    } dst_t;

    //////////////////////////////
    // Stage words.
    //////////////////////////////
    typedef struct packed {
        logic                valid;
        logic [pc_w-1:0]     pc;
        logic [instr_w-1:0]  instr;  // Raw ROM word.
    } fd_t;

    typedef struct packed {
        logic                valid;
        logic [pc_w-1:0]     pc;
        opcode_e             op;
        logic [reg_aw-1:0]   rd;
        logic [data_w-1:0]   a;      // Value of rd.
        logic [data_w-1:0]   b;      // Value of rs.
        logic [data_w-1:0]   imm;
        logic                wr;     // Writes rd.
    } dx_t;

    typedef struct packed {
        logic                valid;
        logic [pc_w-1:0]     pc;
        opcode_e             op;
        logic [reg_aw-1:0]   rd;
        logic [data_w-1:0]   result;
        logic                wr;
    } wb_t;

    typedef struct packed {
        logic                valid;   // One-cycle pulse per retired instruction.
        logic [seq_w-1:0]    seq;
        logic [pc_w-1:0]     pc;
        opcode_e             op;
        logic [reg_aw-1:0]   rd;
        logic [data_w-1:0]   result;
        logic [seq_w-1:0]    stalls;  // Cycles held in decode.
        logic [cyc_w-1:0]    cycle;   // Cycle of write-back.
    } retire_t;

endpackage

// File: fetch_stage.sv
//////////////////////////////
// Fetch stage. PC and instruction ROM, word registered to decode.
//////////////////////////////
`timescale 1ns/1ps

module fetch_stage (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         stall,      // Decode holds its word.
    input  logic         halt_seen,  // HLT has left decode.
    output cpu_pkg::fd_t fd
);
    import cpu_pkg::*;

    logic [instr_w-1:0] rom [imem_depth];  // Program, fixed at elaboration.
    logic [pc_w-1:0]    pc;
    logic               hlt_fetched;       // HLT word already sent.
    logic               run;
    instr_t             word;

    initial $readmemh("program.hex", rom);

    assign word = instr_t'(rom[pc]);
    assign run  = !stall && !halt_seen && !hlt_fetched;  // Advance condition.

    always_ff @(posedge clk) begin
        if (run) begin
            fd.pc    <= pc;       // Payload.
            fd.instr <= rom[pc];
        end
        if (!rst_n) begin
            pc          <= '0;
            hlt_fetched <= 1'b0;
            fd.valid    <= 1'b0;
        end else if (run) begin
            pc          <= pc + 1'b1;
            fd.valid    <= 1'b1;
            hlt_fetched <= (word.op == HLT);  // Last valid word.
        end else if (!stall) begin
            fd.valid    <= 1'b0;              // Nothing after HLT.
        end
    end

endmodule

// File: decode_stage.sv
//////////////////////////////
// Decode stage. Field split, register file with write-through,
// and the interlock against execute and memory.
//////////////////////////////
`timescale 1ns/1ps

module decode_stage (
    input  logic          clk,
    input  logic          rst_n,
    input  cpu_pkg::fd_t  fd,
    input  cpu_pkg::wb_t  wb,
    input  cpu_pkg::dst_t ex_dst,   // Destination in execute.
    input  cpu_pkg::dst_t mem_dst,  // Destination in memory.
    output cpu_pkg::dx_t  dx,
    output logic          stall,
    output logic          halt_seen
);
    import cpu_pkg::*;

    logic [data_w-1:0] regs [reg_n];
    instr_t            ins;
    logic              use_rd;  // Reads rd as operand a.
    logic              use_rs;  // Reads rs as operand b.
    logic              writes;
    logic              wb_we;
    logic [data_w-1:0] rd_val;
    logic [data_w-1:0] rs_val;
    logic              issue;   // Word leaves decode this cycle.

    function automatic logic hit(dst_t d, logic [reg_aw-1:0] r);
        return d.wr && (d.rd == r);
    endfunction

    assign ins = instr_t'(fd.instr);

    always_comb begin
        use_rd = 1'b0;
        use_rs = 1'b0;
        writes = 1'b0;
        case (ins.op)
            LDI: writes = 1'b1;
            ADD, SUB, AND_OP, XOR_OP: begin
                use_rd = 1'b1;
                use_rs = 1'b1;
                writes = 1'b1;
            end
            LD: begin
                use_rs = 1'b1;  // Address base.
                writes = 1'b1;
            end
            ST: begin
                use_rd = 1'b1;  // Store data.
                use_rs = 1'b1;
            end
            default: ;          // NOP, HLT.
        endcase
    end

    // Write-back of this cycle is visible to the read.
    assign wb_we  = wb.valid && wb.wr;
    assign rd_val = (wb_we && wb.rd == ins.rd) ? wb.result : regs[ins.rd];
    assign rs_val = (wb_we && wb.rd == ins.rs) ? wb.result : regs[ins.rs];

    // Interlock. Write-back needs no stall.
    assign stall = fd.valid &&
                   ((use_rd && (hit(ex_dst, ins.rd) || hit(mem_dst, ins.rd))) ||
                    (use_rs && (hit(ex_dst, ins.rs) || hit(mem_dst, ins.rs))));
    assign issue = fd.valid && !stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_n; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_ff @(posedge clk) begin
        dx.pc  <= fd.pc;
        dx.op  <= ins.op;
        dx.rd  <= ins.rd;
        dx.a   <= rd_val;
        dx.b   <= rs_val;
        dx.imm <= ins.imm;
        dx.wr  <= writes;
        if (!rst_n) begin
            dx.valid  <= 1'b0;
            halt_seen <= 1'b0;
        end else begin
            dx.valid <= issue;             // Bubble on stall.
            if (issue && ins.op == HLT) begin
                halt_seen <= 1'b1;         // Sticky.
            end
        end
    end

endmodule

// File: exec_mem_stage.sv
//////////////////////////////
// Execute, memory and write-back registers. ALU and data memory.
//////////////////////////////
`timescale 1ns/1ps

module exec_mem_stage (
    input  logic          clk,
    input  logic          rst_n,
    input  cpu_pkg::dx_t  dx,
    output cpu_pkg::wb_t  wb,
    output cpu_pkg::dst_t ex_dst,
    output cpu_pkg::dst_t mem_dst
);
    import cpu_pkg::*;

    logic [data_w-1:0]  dmem [dmem_depth];
    logic [data_w-1:0]  alu;
    logic [data_w-1:0]  ea;       // rs + imm, before wrap.
    wb_t                m_q;      // Memory stage word.
    logic [dmem_aw-1:0] m_addr;
    logic [data_w-1:0]  m_sdata;  // Store data.

    ////////////////////////////// Execute.
    always_comb begin
        case (dx.op)
            LDI:     alu = dx.imm;
            ADD:     alu = dx.a + dx.b;
            SUB:     alu = dx.a - dx.b;
            AND_OP:  alu = dx.a & dx.b;
            XOR_OP:  alu = dx.a ^ dx.b;
            default: alu = '0;
        endcase
    end

    assign ea = dx.b + dx.imm;

    assign ex_dst.wr  = dx.valid && dx.wr;
    assign ex_dst.rd  = dx.rd;
    assign mem_dst.wr = m_q.valid && m_q.wr;
    assign mem_dst.rd = m_q.rd;

    always_ff @(posedge clk) begin
        m_q.pc     <= dx.pc;
        m_q.op     <= dx.op;
        m_q.rd     <= dx.rd;
        m_q.result <= alu;
        m_q.wr     <= dx.wr;
        m_addr     <= ea[dmem_aw-1:0];  // Wraps modulo 16.
        m_sdata    <= dx.a;
        if (!rst_n) begin
            m_q.valid <= 1'b0;
        end else begin
            m_q.valid <= dx.valid;
        end
    end

    ////////////////////////////// Memory.
    always_ff @(posedge clk) begin
        if (m_q.valid && m_q.op == ST) begin
            dmem[m_addr] <= m_sdata;
        end
    end

    always_ff @(posedge clk) begin
        wb.pc     <= m_q.pc;
        wb.op     <= m_q.op;
        wb.rd     <= m_q.rd;
        wb.wr     <= m_q.wr;
        wb.result <= (m_q.op == LD) ? dmem[m_addr] : m_q.result;  // Load data or ALU.
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= m_q.valid;
        end
    end

endmodule

// File: pipeline_trace.sv
//////////////////////////////
// Trace unit. Follows each instruction by sequence id, counts its
// decode stalls and emits one retire record at write-back.
//////////////////////////////
`timescale 1ns/1ps

module pipeline_trace (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fd_valid,  // Word present in decode.
    input  logic             stall,
    input  cpu_pkg::wb_t     wb,
    output cpu_pkg::retire_t retire,
    output logic             halted
);
    import cpu_pkg::*;

    // Id and stall count carried beside the pipeline.
    typedef struct packed {
        logic [seq_w-1:0] id;
        logic [seq_w-1:0] stalls;
    } tag_t;

    logic [seq_w-1:0] seq_next;    // Id of the word in decode.
    logic [seq_w-1:0] dec_stalls;  // Stalls so far for that word.
    logic [cyc_w-1:0] cyc_cnt;
    logic             advance;
    tag_t             x_tag;
    tag_t             m_tag;
    tag_t             w_tag;

    assign advance = fd_valid && !stall;

    ////////////////////////////// Fetch and decode side, frozen on stall.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq_next   <= '0;
            dec_stalls <= '0;
        end else if (advance) begin
            seq_next   <= seq_next + 1'b1;  // Next fetched word.
            dec_stalls <= '0;
        end else if (fd_valid && stall) begin
            dec_stalls <= dec_stalls + 1'b1;
        end
    end

    // Execute, memory and write-back tags shift every cycle.
    always_ff @(posedge clk) begin
        x_tag.id     <= seq_next;
        x_tag.stalls <= dec_stalls;
        m_tag        <= x_tag;
        w_tag        <= m_tag;   // Lines up with wb.
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc_cnt <= '0;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;  // Free-running.
        end
    end

    ////////////////////////////// Retire record.
    always_ff @(posedge clk) begin
        retire.seq    <= w_tag.id;
        retire.pc     <= wb.pc;
        retire.op     <= wb.op;
        retire.rd     <= wb.rd;
        retire.result <= wb.result;
        retire.stalls <= w_tag.stalls;
        retire.cycle  <= cyc_cnt;
        if (!rst_n) begin
            retire.valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire.valid <= wb.valid;          // One pulse per instruction.
            if (retire.valid && retire.op == HLT) begin
                halted <= 1'b1;                // Cycle after the HLT record.
            end
        end
    end

endmodule

// File: cpu_top.sv
//////////////////////////////
// CPU top level. Pipeline stages plus the trace unit.
//////////////////////////////
`timescale 1ns/1ps

module cpu_top (
    input  logic             clk,
    input  logic             rst_n,
    output cpu_pkg::retire_t retire,
    output logic             halted
);
    import cpu_pkg::*;

    fd_t  fd;         // Fetch to decode.
    dx_t  dx;         // Decode to execute.
    wb_t  wb;         // Write-back, to register file and trace.
    dst_t ex_dst;
    dst_t mem_dst;
    logic stall;
    logic halt_seen;

    fetch_stage u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .halt_seen (halt_seen),
        .fd        (fd)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .fd        (fd),
        .wb        (wb),
        .ex_dst    (ex_dst),
        .mem_dst   (mem_dst),
        .dx        (dx),
        .stall     (stall),
        .halt_seen (halt_seen)
    );

    exec_mem_stage u_exec_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .dx      (dx),
        .wb      (wb),
        .ex_dst  (ex_dst),
        .mem_dst (mem_dst)
    );

    pipeline_trace u_trace (
        .clk      (clk),
        .rst_n    (rst_n),
        .fd_valid (fd.valid),
        .stall    (stall),
        .wb       (wb),
        .retire   (retire),
        .halted   (halted)
    );

endmodule

// File: tb_cpu.sv
//////////////////////////////
// Testbench for the pipelined CPU. Runs program.hex through an ISA model
// and checks every retire record with concurrent assertions.
//////////////////////////////
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int rec_n   = 1 << seq_w;  // Room for every sequence id.
    localparam int drain_n = 8;           // Quiet cycles watched after HLT.

    logic    clk   = 1'b0;
    logic    rst_n = 1'b0;
    retire_t retire;
    logic    halted;

    // Expected records, indexed by sequence id.
    logic [pc_w-1:0]    exp_pc     [rec_n];
    opcode_e            exp_op     [rec_n];
    logic [reg_aw-1:0]  exp_rd     [rec_n];
    logic [data_w-1:0]  exp_result [rec_n];
    logic               exp_wr     [rec_n];
    logic [seq_w-1:0]   exp_stalls [rec_n];
    logic [instr_w-1:0] prog       [imem_depth];
    logic [seq_w-1:0]   n_instr;      // Records up to and including HLT.
    logic [seq_w-1:0]   ret_idx;      // Records seen so far.
    logic               hlt_retired;  // HLT record already seen.
    int                 cyc;          // Cycles since reset release.
    int                 limit;        // Timeout in cycles.

    cpu_top u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .retire (retire),
        .halted (halted)
    );

    always #2 clk = ~clk;  // 4 ns period.

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        abort_run();
    endtask

    ////////////////////////////// ISA model.
    task automatic build_model();
        instr_t             w;
        logic [data_w-1:0]  regs [reg_n];
        logic [data_w-1:0]  mem [dmem_depth];
        int                 last_wr [reg_n];  // Decode slot of the latest writer.
        int                 slot;
        int                 prev;
        int                 cnt;
        int                 i;
        logic               done;
        logic               rd_src;
        logic               rs_src;
        logic               wr;
        logic [data_w-1:0]  res;
        logic [dmem_aw-1:0] addr;
        $readmemh("program.hex", prog);
        for (i = 0; i < reg_n; i++) begin
            regs[i]    = '0;
            last_wr[i] = -8;  // Too old to cost a stall.
        end
        for (i = 0; i < dmem_depth; i++) begin
            mem[i] = '0;
        end
        prev = 0;
        cnt  = 0;
        done = 1'b0;
        for (i = 0; i < imem_depth && !done; i++) begin
            w      = instr_t'(prog[i]);
            rd_src = w.op inside {ADD, SUB, AND_OP, XOR_OP, ST};
            rs_src = w.op inside {ADD, SUB, AND_OP, XOR_OP, LD, ST};
            wr     = w.op inside {LDI, ADD, SUB, AND_OP, XOR_OP, LD};
            addr   = dmem_aw'(regs[w.rs] + w.imm);  // Wraps modulo 16.
            case (w.op)
                LDI:     res = w.imm;
                ADD:     res = regs[w.rd] + regs[w.rs];
                SUB:     res = regs[w.rd] - regs[w.rs];
                AND_OP:  res = regs[w.rd] & regs[w.rs];
                XOR_OP:  res = regs[w.rd] ^ regs[w.rs];
                LD:      res = mem[addr];
                default: res = '0;
            endcase
            // Decode slot: one after the previous, and 3 after any producer.
            slot = prev + 1;
            if (rd_src && last_wr[w.rd] + 3 > slot) slot = last_wr[w.rd] + 3;
            if (rs_src && last_wr[w.rs] + 3 > slot) slot = last_wr[w.rs] + 3;
            if (w.op == ST) mem[addr] = regs[w.rd];
            if (wr) begin
                regs[w.rd]    = res;
                last_wr[w.rd] = slot;
            end
            exp_pc[cnt]     = pc_w'(i);
            exp_op[cnt]     = w.op;
            exp_rd[cnt]     = w.rd;
            exp_result[cnt] = res;
            exp_wr[cnt]     = wr;
            exp_stalls[cnt] = seq_w'(slot - prev - 1);
            prev = slot;
            cnt++;
            if (w.op == HLT) done = 1'b1;
        end
        n_instr = seq_w'(cnt);
        limit   = 5 + 3 * cnt + 10;
    endtask

    ////////////////////////////// Record bookkeeping and timeout.
    always @(posedge clk) begin
        if (!rst_n) begin
            cyc         <= 0;
            ret_idx     <= '0;
            hlt_retired <= 1'b0;
        end else begin
            cyc <= cyc + 1;
            if (retire.valid) ret_idx <= ret_idx + 1'b1;
            if (retire.valid && retire.op == HLT) hlt_retired <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && !hlt_retired && cyc >= limit) begin
            $display("ERROR: timeout, the CPU never halted within %0d cycles", limit);
            abort_run();
        end
    end

    ////////////////////////////// Retire record checks.
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> ret_idx < n_instr)
        else begin
            $display("ERROR: retire record seen after the last program instruction");
            abort_run();
        end
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> retire.seq == ret_idx)  // No gaps in ids.
        else report_mismatch("retire_seq", int'($sampled(ret_idx)), int'($sampled(retire.seq)));
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx < n_instr |-> retire.pc == exp_pc[ret_idx])
        else report_mismatch("retire_pc", int'(exp_pc[$sampled(ret_idx)]),
                             int'($sampled(retire.pc)));
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx < n_instr |-> retire.op == exp_op[ret_idx])
        else report_mismatch("retire_op", int'(exp_op[$sampled(ret_idx)]),
                             int'($sampled(retire.op)));
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx < n_instr |-> retire.rd == exp_rd[ret_idx])
        else report_mismatch("retire_rd", int'(exp_rd[$sampled(ret_idx)]),
                             int'($sampled(retire.rd)));
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx < n_instr && exp_wr[ret_idx] |->
        retire.result == exp_result[ret_idx])  // ALU, LDI and load data.
        else report_mismatch("retire_result", int'(exp_result[$sampled(ret_idx)]),
                             int'($sampled(retire.result)));
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx < n_instr |-> retire.stalls == exp_stalls[ret_idx])
        else report_mismatch("retire_stalls", int'(exp_stalls[$sampled(ret_idx)]),
                             int'($sampled(retire.stalls)));
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> retire.cycle == cyc_w'(cyc - 1))  // Write-back cycle.
        else report_mismatch("retire_cycle", $sampled(cyc) - 1, int'($sampled(retire.cycle)));
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && ret_idx == '0 |-> cyc == 5)  // First fetch is cycle 0.
        else report_mismatch("first_latency", 5, $sampled(cyc));

    ////////////////////////////// Halt checks.
    assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && retire.op == HLT |-> ret_idx == n_instr - 1'b1)
        else report_mismatch("hlt_last", int'(n_instr) - 1, int'($sampled(ret_idx)));
    assert property (@(posedge clk) disable iff (!rst_n)
        !hlt_retired |-> !halted)
        else report_mismatch("halted_low", 0, 1);
    assert property (@(posedge clk) disable iff (!rst_n)
        hlt_retired |-> halted)  // Rises the cycle after HLT.
        else report_mismatch("halted_rise", 1, 0);
    assert property (@(posedge clk) disable iff (!rst_n)
        hlt_retired |-> !retire.valid)
        else begin
            $display("ERROR: retire record seen after the HLT record");
            abort_run();
        end

    ////////////////////////////// Main sequence.
    initial begin
        build_model();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;                    // Inputs move 1 ns after the edge.
        while (!hlt_retired) @(posedge clk);
        repeat (drain_n) @(posedge clk);    // Watch for stray records.
        #1;
        if (ret_idx == n_instr && halted) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("ERROR: run ended with %0d of %0d records retired", ret_idx, n_instr);
            abort_run();
        end
    end

endmodule

// File: program.hex
// One 16-bit instruction per line: opcode nibble, rd and rs bits, 8-bit imm.
// Comment after each word gives the assembly form.
1005  // LDI r0, 0x05
1403  // LDI r1, 0x03
2100  // ADD r0, r1        distance 1 on r1, distance 2 on r0
180A  // LDI r2, 0x0A
0000  // NOP
3800  // SUB r2, r0        distance 2 on r2
7904  // ST  r2, [r1+0x04] address 7
1CF0  // LDI r3, 0xF0
7C0F  // ST  r3, [r0+0x0F] wraps to address 7
6504  // LD  r1, [r1+0x04] reads address 7
5400  // XOR r1, r0        load-use
7712  // ST  r1, [r3+0x12] wraps to address 2
4D00  // AND r3, r1
68FA  // LD  r2, [r0+0xFA] reads address 2
3B00  // SUB r2, r3        load-use
8000  // HLT

// File: files.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
exec_mem_stage.sv
pipeline_trace.sv
cpu_top.sv
tb_cpu.sv

// File: Makefile
# Verilator flow for the pipelined CPU testbench.
# Run from the project root so that program.hex is found.

VERILATOR  ?= verilator
TOP        ?= tb_cpu
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard *.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(BUILD_DIR)
